//--- Bender.yml
package:
  name: mips_cpu

sources:
  - files:
      - logic/mips_pkg.sv
      - logic/mips_cpu_register.sv
      - logic/mips_decoder.sv
      - logic/mips_alu.sv
      - logic/mips_pc_unit.sv
      - logic/mips_cpu.sv
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/mips_cpu_asserts.sv
      - testbench/mips_cpu_tb.sv

//--- files.f
logic/mips_pkg.sv
logic/mips_cpu_register.sv
logic/mips_decoder.sv
logic/mips_alu.sv
logic/mips_pc_unit.sv
logic/mips_cpu.sv
testbench/tb_clock.sv
testbench/mips_cpu_asserts.sv
testbench/mips_cpu_tb.sv

//--- logic/mips_alu.sv
module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   result,
    output logic              zero
);
    import mips_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;    // addu semantics without overflow trap
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_NOR:    result = ~(a | b);
            ALU_SLT:    result = {31'd0, lt_signed};
            ALU_SLTU:   result = {31'd0, lt_unsigned};
            ALU_PASS_B: result = b;
            default:    result = '0;    // unused encodings of the 4-bit op
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- logic/mips_cpu.sv
module mips_cpu #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    output mips_pkg::word_t instr_addr,
    input  mips_pkg::word_t instr_data,
    output mips_pkg::word_t data_addr,
    output mips_pkg::word_t data_wdata,
    output logic            data_read,
    output logic            data_write,
    input  mips_pkg::word_t data_rdata,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    word_t    pc;
    ctrl_t    ctrl;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    read_data_1;
    word_t    read_data_2;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_zero;
    word_t    write_back;
    logic     reg_write;
    logic     take_branch;

    mips_pc_unit #(
        .RESET_VECTOR (RESET_VECTOR)
    ) pc_unit0 (
        .clk           (clk),
        .reset         (reset),
        .take_branch   (take_branch),
        .branch_offset (ctrl.imm),
        .jump          (ctrl.jump),
        .jump_index    (ctrl.jump_index),
        .pc            (pc)
    );

    assign instr_addr = pc;

    mips_decoder decoder0 (
        .instr (instr_data),
        .ctrl  (ctrl),
        .rs    (rs),
        .rt    (rt)
    );

    mips_cpu_register regfile0 (
        .clk             (clk),
        .reset           (reset),
        .read_register_1 (rs),
        .read_register_2 (rt),
        .write_register  (ctrl.dest),
        .write_data      (write_back),
        .reg_write       (reg_write),
        .read_data_1     (read_data_1),
        .read_data_2     (read_data_2),
        .register_v0     (register_v0)
    );

    assign alu_b = ctrl.alu_src_imm ? ctrl.imm : read_data_2;

    mips_alu alu0 (
        .op     (ctrl.alu_op),
        .a      (read_data_1),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign take_branch = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

    // decoded strobes are held off while in reset
    assign reg_write  = ctrl.reg_write && !reset;
    assign data_read  = ctrl.mem_read && !reset;
    assign data_write = ctrl.mem_write && !reset;

    assign data_addr  = alu_result;     // low two bits ignored by memory
    assign data_wdata = read_data_2;    // rt for sw
    assign write_back = ctrl.mem_read ? data_rdata : alu_result;

endmodule

//--- logic/mips_cpu_register.sv
module mips_cpu_register (
    input  logic               clk,
    input  logic               reset,
    input  mips_pkg::reg_idx_t read_register_1,
    input  mips_pkg::reg_idx_t read_register_2,
    input  mips_pkg::reg_idx_t write_register,
    input  mips_pkg::word_t    write_data,
    input  logic               reg_write,
    output mips_pkg::word_t    read_data_1,
    output mips_pkg::word_t    read_data_2,
    output mips_pkg::word_t    register_v0
);
    import mips_pkg::*;

    localparam int NUM_REGS = 32;
    localparam reg_idx_t REG_V0 = 5'd2;

    word_t regs [NUM_REGS];    // gpr file where entry 0 is written but never read back

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;    // all gprs cleared
            end
        end else if (reg_write) begin
            regs[write_register] <= write_data;
        end
    end

    // r0 reads as zero whatever was written to it
    assign read_data_1 = (reset || read_register_1 == '0) ? '0 : regs[read_register_1];
    assign read_data_2 = (reset || read_register_2 == '0) ? '0 : regs[read_register_2];

    assign register_v0 = regs[REG_V0];    // v0 tap for observation

endmodule

//--- logic/mips_decoder.sv
module mips_decoder (
    input  mips_pkg::word_t    instr,
    output mips_pkg::ctrl_t    ctrl,
    output mips_pkg::reg_idx_t rs,
    output mips_pkg::reg_idx_t rt
);
    import mips_pkg::*;

    opcode_t     opcode;
    funct_t      funct;
    reg_idx_t    rd;
    logic [15:0] imm16;
    word_t       imm_sext;
    word_t       imm_zext;
    word_t       imm_upper;

    assign opcode = opcode_t'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = funct_t'(instr[5:0]);    // shamt is not used by the subset
    assign imm16  = instr[15:0];

    assign imm_sext  = {{16{imm16[15]}}, imm16};
    assign imm_zext  = {16'h0000, imm16};
    assign imm_upper = {imm16, 16'h0000};    // lui

    always_comb begin
        ctrl = '0;    // anything unmatched stays a nop
        case (opcode)
            OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rd;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_NOR:  ctrl.alu_op = ALU_NOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    default: ctrl = '0;    // includes sll 0 as the all-zero word
                endcase
            end
            OP_ADDIU, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.dest        = rt;
                case (opcode)
                    OP_ADDIU: begin
                        ctrl.alu_op = ALU_ADD;
                        ctrl.imm    = imm_sext;
                    end
                    OP_SLTIU: begin
                        ctrl.alu_op = ALU_SLTU;    // sign-extended but compared unsigned
                        ctrl.imm    = imm_sext;
                    end
                    OP_ANDI: begin
                        ctrl.alu_op = ALU_AND;
                        ctrl.imm    = imm_zext;
                    end
                    OP_ORI: begin
                        ctrl.alu_op = ALU_OR;
                        ctrl.imm    = imm_zext;
                    end
                    OP_XORI: begin
                        ctrl.alu_op = ALU_XOR;
                        ctrl.imm    = imm_zext;
                    end
                    default: begin
                        ctrl.alu_op = ALU_PASS_B;
                        ctrl.imm    = imm_upper;
                    end
                endcase
            end
            OP_LW, OP_SW: begin
                ctrl.alu_op      = ALU_ADD;    // base + offset
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_sext;
                ctrl.reg_write   = (opcode == OP_LW);
                ctrl.dest        = rt;
                ctrl.mem_read    = (opcode == OP_LW);
                ctrl.mem_write   = (opcode == OP_SW);
            end
            OP_BEQ, OP_BNE: begin
                ctrl.alu_op    = ALU_SUB;    // zero flag gives rs == rt
                ctrl.imm       = imm_sext;
                ctrl.branch_eq = (opcode == OP_BEQ);
                ctrl.branch_ne = (opcode == OP_BNE);
            end
            OP_J: begin
                ctrl.jump       = 1'b1;
                ctrl.jump_index = instr[25:0];
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- logic/mips_pc_unit.sv
module mips_pc_unit #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            take_branch,
    input  mips_pkg::word_t branch_offset,
    input  logic            jump,
    input  logic [25:0]     jump_index,
    output mips_pkg::word_t pc
);
    import mips_pkg::*;

    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    word_t next_pc;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {branch_offset[29:0], 2'b00};    // word offset
    assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};        // same 256MB region

    always_comb begin
        if (jump) begin
            next_pc = jump_target;    // jump wins over a branch
        end else if (take_branch) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= next_pc;    // no delay slot
        end
    end

endmodule

//--- logic/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // primary opcodes in instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,    // register forms decoded by funct
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // SPECIAL function codes in instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B    // operand b straight through for lui
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        alu_src_imm;    // operand b from imm instead of rt
        word_t       imm;            // already extended or shifted
        logic        reg_write;
        reg_idx_t    dest;           // rd or rt
        logic        mem_read;
        logic        mem_write;
        logic        branch_eq;
        logic        branch_ne;
        logic        jump;
        logic [25:0] jump_index;
    } ctrl_t;

endpackage

//--- testbench/mips_cpu_asserts.sv
module mips_cpu_asserts (
    input logic            clk,
    input logic            reset,
    input mips_pkg::word_t instr_addr,
    input logic            data_read,
    input logic            data_write
);

    // a single-cycle core does one memory access at most
    strobe_exclusive: assert property (@(posedge clk) !(data_read && data_write))
        else $error("data_read and data_write are high in the same cycle");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        instr_addr[1:0] == 2'b00)
        else $error("instr_addr is not word aligned");

    quiet_in_reset: assert property (@(posedge clk) reset |-> (!data_read && !data_write))
        else $error("memory strobe high while reset is high");

endmodule

bind mips_cpu mips_cpu_asserts asserts0 (
    .clk        (clk),
    .reset      (reset),
    .instr_addr (instr_addr),
    .data_read  (data_read),
    .data_write (data_write)
);

//--- testbench/mips_cpu_tb.sv
module mips_cpu_tb;
    import mips_pkg::*;

    localparam word_t PROG_BASE    = 32'h0000_0400;
    localparam word_t DATA_BASE    = 32'h0000_0100;
    localparam int    PROG_WORDS   = 64;
    localparam int    DATA_WORDS   = 64;
    localparam int    RUN_CYCLES   = 400;
    localparam int    RESET_CYCLES = 16;
    localparam int    MID_RESET_AT = 200;
    localparam time   RUN_LIMIT    = 40 * (RUN_CYCLES + 4 * RESET_CYCLES + 40);

    logic  clk;
    logic  reset;
    word_t instr_addr;
    word_t instr_data;
    word_t data_addr;
    word_t data_wdata;
    logic  data_read;
    logic  data_write;
    word_t data_rdata;
    word_t register_v0;

    word_t prog   [PROG_WORDS];
    word_t dmem   [DATA_WORDS];    // memory behind the dut ports
    word_t m_mem  [DATA_WORDS];    // model's view of the same region
    word_t m_regs [32];
    word_t m_pc;
    int    errors;
    int    checked;
    bit    timed_out;

    tb_clock #(.PERIOD(40)) clock0 (.clk(clk));

    mips_cpu #(
        .RESET_VECTOR (32'h0000_0400)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_rdata  (data_rdata),
        .register_v0 (register_v0)
    );

    // both memories answer in the same cycle and read zero outside their window
    assign instr_data = (instr_addr[31:8] == PROG_BASE[31:8]) ? prog[instr_addr[7:2]] : '0;
    assign data_rdata = (data_addr[31:8] == DATA_BASE[31:8]) ? dmem[data_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (data_write && data_addr[31:8] == DATA_BASE[31:8]) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic word_t r_format(input funct_t fn, input reg_idx_t s, input reg_idx_t t,
                                       input reg_idx_t d);
        return {OP_SPECIAL, s, t, d, 5'd0, fn};
    endfunction

    function automatic word_t i_format(input opcode_t op, input reg_idx_t s, input reg_idx_t t,
                                       input logic [15:0] imm);
        return {op, s, t, imm};
    endfunction

    function automatic word_t j_format(input logic [25:0] index);
        return {OP_J, index};
    endfunction

    function automatic reg_idx_t pick_dest();
        return ($urandom_range(0, 2) == 0) ? 5'd2 : 5'($urandom_range(0, 7));    // lean on v0
    endfunction

    function automatic reg_idx_t pick_src();
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic funct_t pick_funct();
        case ($urandom_range(0, 7))
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_NOR;
            6: return FN_SLT;
            default: return FN_SLTU;
        endcase
    endfunction

    function automatic opcode_t pick_imm_op();
        case ($urandom_range(0, 5))
            0: return OP_ADDIU;
            1: return OP_SLTIU;
            2: return OP_ANDI;
            3: return OP_ORI;
            4: return OP_XORI;
            default: return OP_LUI;
        endcase
    endfunction

    task automatic build_program();
        int          kind;
        int          target;
        logic [15:0] offset;
        logic [15:0] imm;
        logic [15:0] data_off;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind   = $urandom_range(0, 10);
            target = $urandom_range(0, PROG_WORDS - 1);
            if (target == i) begin
                target = (i + 2) % PROG_WORDS;    // no branch onto itself
            end
            offset   = 16'(target - (i + 1));
            imm      = 16'($urandom());
            data_off = 16'(DATA_BASE + 4 * $urandom_range(0, DATA_WORDS - 1));
            case (kind)
                0, 1, 2: prog[i] = r_format(pick_funct(), pick_src(), pick_src(), pick_dest());
                3, 4:    prog[i] = i_format(pick_imm_op(), pick_src(), pick_dest(), imm);
                5:       prog[i] = i_format(OP_LW, 5'd0, pick_dest(), data_off);
                6:       prog[i] = i_format(OP_SW, 5'd0, pick_src(), data_off);
                7:       prog[i] = i_format(OP_BEQ, pick_src(), pick_src(), offset);
                8:       prog[i] = i_format(OP_BNE, pick_src(), pick_src(), offset);
                9:       prog[i] = j_format(26'((PROG_BASE >> 2) + target));
                default: prog[i] = '0;
            endcase
        end
        prog[PROG_WORDS - 1] = j_format(PROG_BASE[27:2]);    // loop back to the start
    endtask

    task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
        errors++;
        $display("ERR %s expected %h actual %h (t=%0t)", name, expected, actual, $time);
    endtask

    task automatic model_reset();
        m_pc = PROG_BASE;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
    endtask

    // with fresh set the reset was raised at the last edge and the dut has not clocked it yet
    task automatic hold_reset(input int cycles, input bit fresh);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (data_read !== 1'b0) report_mismatch("reset_strobe", 32'd0, 32'(data_read));
            if (data_write !== 1'b0) report_mismatch("reset_strobe", 32'd0, 32'(data_write));
            if (!(fresh && i == 0)) begin
                if (instr_addr !== PROG_BASE) report_mismatch("reset_pc", PROG_BASE, instr_addr);
                if (register_v0 !== '0) report_mismatch("reset_v0", 32'd0, register_v0);
            end
            @(posedge clk);
            if (i == cycles - 1) begin
                reset <= 1'b0;
            end
        end
    endtask

    task automatic wait_fetch(input word_t addr, input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (instr_addr !== addr && !timed_out) begin
            if (waited >= limit) begin
                $display("timeout: no fetch from %h within %0d cycles after reset", addr, limit);
                errors++;
                timed_out = 1'b1;
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // steps the reference model by one instruction and compares this cycle's ports
    task automatic step_and_check();
        word_t    instr;
        word_t    a;
        word_t    b;
        word_t    sext;
        word_t    zext;
        word_t    pc4;
        word_t    addr;
        word_t    result;
        word_t    next_pc;
        reg_idx_t dest;
        logic     wr;
        logic     ld;
        logic     st;

        instr   = (m_pc[31:8] == PROG_BASE[31:8]) ? prog[m_pc[7:2]] : '0;
        a       = m_regs[instr[25:21]];
        b       = m_regs[instr[20:16]];
        sext    = {{16{instr[15]}}, instr[15:0]};
        zext    = {16'h0000, instr[15:0]};
        pc4     = m_pc + 32'd4;
        next_pc = pc4;
        addr    = a + sext;
        result  = '0;
        dest    = instr[20:16];
        wr      = 1'b0;
        ld      = (instr[31:26] == OP_LW);
        st      = (instr[31:26] == OP_SW);
        case (instr[31:26])
            OP_SPECIAL: begin
                dest = instr[15:11];
                wr   = 1'b1;
                case (instr[5:0])
                    FN_ADDU: result = a + b;
                    FN_SUBU: result = a - b;
                    FN_AND:  result = a & b;
                    FN_OR:   result = a | b;
                    FN_XOR:  result = a ^ b;
                    FN_NOR:  result = ~(a | b);
                    FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: result = (a < b) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;    // other funct codes and the zero word
                endcase
            end
            OP_ADDIU, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                wr = 1'b1;
                case (instr[31:26])
                    OP_ADDIU: result = a + sext;
                    OP_SLTIU: result = (a < sext) ? 32'd1 : 32'd0;
                    OP_ANDI:  result = a & zext;
                    OP_ORI:   result = a | zext;
                    OP_XORI:  result = a ^ zext;
                    OP_LUI:   result = {instr[15:0], 16'h0000};
                    default:  result = m_mem[addr[7:2]];
                endcase
            end
            OP_BEQ: if (a == b) next_pc = pc4 + {sext[29:0], 2'b00};
            OP_BNE: if (a != b) next_pc = pc4 + {sext[29:0], 2'b00};
            OP_J:   next_pc = {pc4[31:28], instr[25:0], 2'b00};
            default: ;
        endcase

        if (instr_addr !== m_pc) report_mismatch("instr_flow", m_pc, instr_addr);
        if (register_v0 !== m_regs[2]) report_mismatch("reg_v0", m_regs[2], register_v0);
        if (data_read !== ld) report_mismatch("load_strobe", 32'(ld), 32'(data_read));
        if (data_write !== st) report_mismatch("store_strobe", 32'(st), 32'(data_write));
        if ((ld || st) && data_addr !== addr) report_mismatch("mem_addr", addr, data_addr);
        if (st && data_wdata !== b) report_mismatch("store_data", b, data_wdata);

        if (st) m_mem[addr[7:2]] = b;
        if (wr && dest != '0) m_regs[dest] = result;    // r0 stays zero
        m_pc = next_pc;
    endtask

    initial begin
        int cycle;
        errors    = 0;
        checked   = 0;
        timed_out = 1'b0;
        reset     = 1'b1;
        void'($urandom(32'h465c));
        build_program();
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i]  = fill_word(DATA_BASE + 32'(i * 4));
            m_mem[i] = fill_word(DATA_BASE + 32'(i * 4));
        end
        hold_reset(RESET_CYCLES - 1, 1'b0);    // the edge before the loop is the first one
        model_reset();
        wait_fetch(PROG_BASE, 4);
        cycle = 0;
        while (cycle < RUN_CYCLES && !timed_out) begin
            if ($time > RUN_LIMIT) begin
                $display("timeout: run did not complete %0d cycles in time", RUN_CYCLES);
                errors++;
                timed_out = 1'b1;
            end else begin
                step_and_check();
                checked++;
                @(posedge clk);
                cycle++;
                if (cycle == MID_RESET_AT) begin
                    reset <= 1'b1;
                    hold_reset(RESET_CYCLES, 1'b1);
                    model_reset();
                    wait_fetch(PROG_BASE, 4);
                end else begin
                    @(negedge clk);
                end
            end
        end
        $display("cycles checked %0d, errors %0d", checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;    // first rising edge at half a period
        end
    end

endmodule
